// File: rtl/sv32_pkg.sv
// Sv32 MMU shared definitions
// Field widths, PTE flag positions, TLB sizes, enums and the
// request/response structs used between the MMU blocks
`default_nettype none

package sv32_pkg;

  // Address split
  localparam int SV32_PAGE_OFFSET_BITS = 12;
  localparam int SV32_VPN_BITS         = 10;
  localparam int SV32_TAG_BITS         = 2 * SV32_VPN_BITS;
  localparam int SV32_PTE_PPN_SHIFT    = 10;

  // Flag positions inside a PTE
  localparam int PTE_V = 0;
  localparam int PTE_R = 1;
  localparam int PTE_W = 2;
  localparam int PTE_X = 3;
  localparam int PTE_A = 6;
  localparam int PTE_D = 7;

  // TLB geometry with both sizes a power of two
  localparam int ITLB_ENTRIES  = 16;
  localparam int DTLB_ENTRIES  = 16;
  localparam int ITLB_IDX_BITS = $clog2(ITLB_ENTRIES);
  localparam int DTLB_IDX_BITS = $clog2(DTLB_ENTRIES);

  // Fetch goes to the ITLB, loads and stores to the DTLB
  typedef enum logic [1:0] {
    ACC_FETCH,
    ACC_LOAD,
    ACC_STORE
  } access_t;

  typedef enum logic [1:0] {
    WALK_IDLE,
    WALK_LOOKUP,
    WALK_FETCH
  } walk_state_t;

  typedef struct packed {
    logic        mode;
    logic [8:0]  asid;
    logic [21:0] ppn;
  } satp_t;

  typedef struct packed {
    logic [31:0] vaddr;
    access_t     access;
  } mmu_req_t;

  typedef struct packed {
    logic [31:0] paddr;
    logic        fault;
  } mmu_resp_t;

endpackage

`default_nettype wire

// File: rtl/tlb_tag_ram.sv
// Direct-mapped TLB tag RAM
// Holds one translated PTE per entry with a valid bit, a full VPN tag
// and a flash clear of all valid bits
`timescale 1ns/100ps
`default_nettype none

module tlb_tag_ram #(
  parameter int ADDR_WIDTH = 4
) (
  input  wire logic                                clk_i,
  input  wire logic                                resetn_i,
  input  wire logic                                flush_i,
  input  wire logic [ADDR_WIDTH-1:0]               idx_i,
  input  wire logic [sv32_pkg::SV32_TAG_BITS-1:0]  tag_i,
  input  wire logic                                we_i,
  input  wire logic                                lookup_i,
  input  wire logic [31:0]                         payload_i,
  output logic                                     hit_o,
  output logic [31:0]                              payload_o
);
  import sv32_pkg::*;

  localparam int ENTRIES = 1 << ADDR_WIDTH;

  logic [SV32_TAG_BITS-1:0] tag_q     [ENTRIES];
  logic [31:0]              payload_q [ENTRIES];
  logic [ENTRIES-1:0]       valid_q;

  // Valid bits with flush taking priority over a refill
  always_ff @(posedge clk_i) begin
    if (!resetn_i || flush_i) begin
      valid_q <= '0;
    end else if (we_i) begin
      valid_q[idx_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      tag_q[idx_i]     <= tag_i;
      payload_q[idx_i] <= payload_i;
    end
  end

  assign hit_o     = lookup_i && valid_q[idx_i] && (tag_q[idx_i] == tag_i);
  assign payload_o = payload_q[idx_i];

endmodule

`default_nettype wire

// File: rtl/sv32_table_walk.sv
// Sv32 table walker
// Bare-mode bypass, ITLB/DTLB lookup, two-level page-table walk over a
// simple read port and TLB refill with the translated leaf PTE
`timescale 1ns/100ps
`default_nettype none

module sv32_table_walk (
  input  wire logic               clk,
  input  wire logic               resetn,
  input  wire logic               req_valid_i,
  input  wire sv32_pkg::mmu_req_t req_i,
  input  wire sv32_pkg::satp_t    satp_i,
  input  wire logic               tlb_flush_i,
  input  wire logic               walk_mem_ready_i,
  input  wire logic [31:0]        walk_mem_rdata_i,
  output logic [31:0]             pte_o,
  output logic                    ready_o,
  output logic                    walk_mem_valid_o,
  output logic [31:0]             walk_mem_addr_o
);
  import sv32_pkg::*;

  walk_state_t state_q;
  logic        level_q;
  logic [31:0] base_q;
  logic [31:0] pte_q;
  logic        ready_q;
  logic        mem_valid_q;
  logic [31:0] mem_addr_q;

  logic [SV32_TAG_BITS-1:0] vpn;
  logic [SV32_VPN_BITS-1:0] vpn_slice;
  logic                     is_fetch;
  logic                     lookup_en;
  logic                     itlb_hit;
  logic                     dtlb_hit;
  logic                     tlb_hit;
  logic [31:0]              itlb_pte;
  logic [31:0]              dtlb_pte;
  logic [31:0]              tlb_pte;
  logic [31:0]              bare_pte;
  logic [31:0]              leaf_pte;
  logic                     pte_valid;
  logic                     pte_pointer;
  logic                     refill;

  assign vpn       = req_i.vaddr[31:SV32_PAGE_OFFSET_BITS];
  assign vpn_slice = level_q ? vpn[SV32_TAG_BITS-1:SV32_VPN_BITS] : vpn[SV32_VPN_BITS-1:0];
  assign is_fetch  = (req_i.access == ACC_FETCH);
  assign lookup_en = (state_q == WALK_LOOKUP);
  assign tlb_hit   = is_fetch ? itlb_hit : dtlb_hit;
  assign tlb_pte   = is_fetch ? itlb_pte : dtlb_pte;

  // Identity page with full permissions
  always_comb begin
    bare_pte        = {2'b00, vpn, 10'b0};
    bare_pte[PTE_V] = 1'b1;
    bare_pte[PTE_R] = 1'b1;
    bare_pte[PTE_W] = 1'b1;
    bare_pte[PTE_X] = 1'b1;
    bare_pte[PTE_A] = 1'b1;
    bare_pte[PTE_D] = 1'b1;
  end

  assign pte_valid   = walk_mem_rdata_i[PTE_V];
  assign pte_pointer = !walk_mem_rdata_i[PTE_R] && !walk_mem_rdata_i[PTE_W] &&
                       !walk_mem_rdata_i[PTE_X];

  // Superpage leaf takes VPN0 from the virtual address
  assign leaf_pte = level_q ?
      {walk_mem_rdata_i[31:SV32_PTE_PPN_SHIFT+SV32_VPN_BITS], vpn[SV32_VPN_BITS-1:0],
       walk_mem_rdata_i[SV32_PTE_PPN_SHIFT-1:0]} :
      walk_mem_rdata_i;

  assign refill = (state_q == WALK_FETCH) && walk_mem_ready_i && pte_valid && !pte_pointer;

  tlb_tag_ram #(
    .ADDR_WIDTH(ITLB_IDX_BITS)
  ) itlb_i (
    .clk_i    (clk),
    .resetn_i (resetn),
    .flush_i  (tlb_flush_i),
    .idx_i    (vpn[ITLB_IDX_BITS-1:0]),
    .tag_i    (vpn),
    .we_i     (refill && is_fetch),
    .lookup_i (lookup_en && is_fetch),
    .payload_i(leaf_pte),
    .hit_o    (itlb_hit),
    .payload_o(itlb_pte)
  );

  tlb_tag_ram #(
    .ADDR_WIDTH(DTLB_IDX_BITS)
  ) dtlb_i (
    .clk_i    (clk),
    .resetn_i (resetn),
    .flush_i  (tlb_flush_i),
    .idx_i    (vpn[DTLB_IDX_BITS-1:0]),
    .tag_i    (vpn),
    .we_i     (refill && !is_fetch),
    .lookup_i (lookup_en && !is_fetch),
    .payload_i(leaf_pte),
    .hit_o    (dtlb_hit),
    .payload_o(dtlb_pte)
  );

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state_q     <= WALK_IDLE;
      level_q     <= 1'b1;
      ready_q     <= 1'b0;
      mem_valid_q <= 1'b0;
    end else begin
      ready_q <= 1'b0;
      case (state_q)
        WALK_IDLE: begin
          // Skip the edge where the requester is still dropping valid
          if (req_valid_i && !ready_q) begin
            if (satp_i.mode) begin
              base_q  <= {satp_i.ppn[19:0], 12'b0};
              level_q <= 1'b1;
              state_q <= WALK_LOOKUP;
            end else begin
              pte_q   <= bare_pte;
              ready_q <= 1'b1;
            end
          end
        end
        WALK_LOOKUP: begin
          if (tlb_hit) begin
            pte_q   <= tlb_pte;
            ready_q <= 1'b1;
            state_q <= WALK_IDLE;
          end else begin
            mem_valid_q <= 1'b1;
            mem_addr_q  <= base_q + {20'b0, vpn_slice, 2'b00};
            state_q     <= WALK_FETCH;
          end
        end
        WALK_FETCH: begin
          if (walk_mem_ready_i) begin
            mem_valid_q <= 1'b0;
            if (pte_valid && pte_pointer && level_q) begin
              base_q  <= {walk_mem_rdata_i[SV32_PTE_PPN_SHIFT +: 20], 12'b0};
              level_q <= 1'b0;
              state_q <= WALK_LOOKUP;
            end else begin
              // Invalid entry or pointer at level 0 ends as a zero PTE
              pte_q   <= refill ? leaf_pte : 32'b0;
              ready_q <= 1'b1;
              state_q <= WALK_IDLE;
            end
          end
        end
        default: state_q <= WALK_IDLE;
      endcase
    end
  end

  assign pte_o            = pte_q;
  assign ready_o          = ready_q;
  assign walk_mem_valid_o = mem_valid_q;
  assign walk_mem_addr_o  = mem_addr_q;

  // One response per request
  a_ready_pulse: assert property (@(posedge clk) disable iff (!resetn)
    ready_q |=> !ready_q);

  // No memory read left hanging once the walk has ended
  a_idle_no_read: assert property (@(posedge clk) disable iff (!resetn)
    (state_q == WALK_IDLE) |-> !mem_valid_q);

endmodule

`default_nettype wire

// File: rtl/mmu_access_check.sv
// MMU access check
// Forms the physical address from a translated PTE and flags a fault
// when the access type is not permitted by the PTE flags
`timescale 1ns/100ps
`default_nettype none

module mmu_access_check (
  input  wire logic [31:0]        pte_i,
  input  wire sv32_pkg::mmu_req_t req_i,
  input  wire logic               ready_i,
  output sv32_pkg::mmu_resp_t     resp_o
);
  import sv32_pkg::*;

  logic flag_v;
  logic flag_r;
  logic flag_w;
  logic flag_x;
  logic flag_a;
  logic flag_d;
  logic perm_fault;

  assign flag_v = pte_i[PTE_V];
  assign flag_r = pte_i[PTE_R];
  assign flag_w = pte_i[PTE_W];
  assign flag_x = pte_i[PTE_X];
  assign flag_a = pte_i[PTE_A];
  assign flag_d = pte_i[PTE_D];

  // A and D are never set by hardware, so a clear bit is a fault
  always_comb begin
    case (req_i.access)
      ACC_FETCH: perm_fault = !flag_x;
      ACC_LOAD:  perm_fault = !flag_r;
      ACC_STORE: perm_fault = !flag_w || !flag_d;
      default:   perm_fault = 1'b1;
    endcase
  end

  // Upper two PPN bits dropped for a 32-bit physical address
  assign resp_o.paddr = {pte_i[SV32_PTE_PPN_SHIFT +: 20],
                         req_i.vaddr[SV32_PAGE_OFFSET_BITS-1:0]};
  assign resp_o.fault = !flag_v || !flag_a || perm_fault;

  // Checked as ready falls, on the values held during the ready cycle
  a_resp_known: assert property (@(negedge ready_i)
    ready_i |-> !$isunknown(resp_o));

endmodule

`default_nettype wire

// File: rtl/sv32_mmu.sv
// Sv32 MMU top level
// Table walker followed by a combinational access check
`timescale 1ns/100ps
`default_nettype none

module sv32_mmu (
  input  wire logic                clk,
  input  wire logic                resetn,
  input  wire logic                req_valid_i,
  input  wire sv32_pkg::mmu_req_t  req_i,
  input  wire sv32_pkg::satp_t     satp_i,
  input  wire logic                tlb_flush_i,
  output logic                     walk_mem_valid_o,
  output logic [31:0]              walk_mem_addr_o,
  input  wire logic                walk_mem_ready_i,
  input  wire logic [31:0]         walk_mem_rdata_i,
  output logic                     resp_valid_o,
  output sv32_pkg::mmu_resp_t      resp_o
);

  logic [31:0] pte;
  logic        walk_ready;

  sv32_table_walk sv32_table_walk_i (
    .clk             (clk),
    .resetn          (resetn),
    .req_valid_i     (req_valid_i),
    .req_i           (req_i),
    .satp_i          (satp_i),
    .tlb_flush_i     (tlb_flush_i),
    .walk_mem_ready_i(walk_mem_ready_i),
    .walk_mem_rdata_i(walk_mem_rdata_i),
    .pte_o           (pte),
    .ready_o         (walk_ready),
    .walk_mem_valid_o(walk_mem_valid_o),
    .walk_mem_addr_o (walk_mem_addr_o)
  );

  mmu_access_check mmu_access_check_i (
    .pte_i  (pte),
    .req_i  (req_i),
    .ready_i(walk_ready),
    .resp_o (resp_o)
  );

  // Response is valid for exactly the walker ready cycle
  assign resp_valid_o = walk_ready;

endmodule

`default_nettype wire

// File: testbench/tb_sv32_mmu.sv
// Sv32 MMU testbench
// Directed tests over a page-table memory model, checked against a reference walk
`timescale 1ns/100ps
`default_nettype none

module tb_sv32_mmu;
  import sv32_pkg::*;

  localparam int          NUM_TESTS = 6;
  localparam logic [31:0] ROOT      = 32'h0001_0000;
  localparam logic [31:0] L0        = 32'h0002_0000;
  // VPN1 0x101 leads through the level-1 pointer to VPN0 0x003
  localparam logic [31:0] VA_PAGE   = 32'h4040_3000;
  // VPN1 0x0C0 is a level-1 leaf
  localparam logic [31:0] VA_SUPER  = 32'h302A_5000;

  logic        clk;
  logic        resetn;
  logic        req_valid_i;
  mmu_req_t    req_i;
  satp_t       satp_i;
  logic        tlb_flush_i;
  logic        walk_mem_valid_o;
  logic [31:0] walk_mem_addr_o;
  logic        walk_mem_ready_i = 1'b0;
  logic [31:0] walk_mem_rdata_i = '0;
  logic        resp_valid_o;
  mmu_resp_t   resp_o;
  logic        mem_wait = 1'b0;
  logic [31:0] mem [logic [31:0]];
  logic [31:0] read_addrs [$];
  int          mem_reads = 0;
  int          errors = 0;

  sv32_mmu sv32_mmu_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] read_word(logic [31:0] addr);
    return mem.exists(addr) ? mem[addr] : 32'h0;
  endfunction

  function automatic logic [31:0] make_pte(logic [31:0] page, logic [7:0] flags);
    return {2'b00, page[31:12], 2'b00, flags};
  endfunction

  // Page-table memory answering two cycles after a read is raised
  always @(posedge clk) begin
    if (walk_mem_ready_i) begin
      walk_mem_ready_i <= 1'b0;
      mem_wait         <= 1'b0;
    end else if (walk_mem_valid_o && mem_wait) begin
      walk_mem_ready_i <= 1'b1;
      walk_mem_rdata_i <= read_word(walk_mem_addr_o);
      mem_reads        <= mem_reads + 1;
      read_addrs.push_back(walk_mem_addr_o);
    end else if (walk_mem_valid_o) begin
      mem_wait <= 1'b1;
    end
  end

  // Reference Sv32 translation over the same memory image
  function automatic mmu_resp_t ref_translate(logic [31:0] va, access_t acc);
    mmu_resp_t   r;
    logic [31:0] base;
    logic [31:0] pte;
    logic [9:0]  slice;
    logic        level;
    logic        leaf;
    logic        done;
    r = '{paddr: va, fault: 1'b0};
    if (!satp_i.mode)
      return r;
    base  = {satp_i.ppn[19:0], 12'h0};
    level = 1'b1;
    leaf  = 1'b0;
    done  = 1'b0;
    pte   = '0;
    while (!done) begin
      slice = level ? va[31:22] : va[21:12];
      pte   = read_word(base + 32'(slice) * 4);
      if (!pte[PTE_V] || pte[PTE_R] || pte[PTE_W] || pte[PTE_X] || !level) begin
        leaf = pte[PTE_V] && (pte[PTE_R] || pte[PTE_W] || pte[PTE_X]);
        done = 1'b1;
      end else begin
        base  = {pte[29:10], 12'h0};
        level = 1'b0;
      end
    end
    if (!leaf) begin
      r.fault = 1'b1;
      return r;
    end
    r.paddr = level ? {pte[29:20], va[21:0]} : {pte[29:10], va[11:0]};
    case (acc)
      ACC_FETCH: r.fault = !pte[PTE_X];
      ACC_LOAD:  r.fault = !pte[PTE_R];
      default:   r.fault = !pte[PTE_W] || !pte[PTE_D];
    endcase
    r.fault = r.fault || !pte[PTE_A];
    return r;
  endfunction

  task automatic check(string what, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERR @%0t: %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // One request at a random page offset checked against the reference walk
  task automatic translate(logic [31:0] page, access_t acc, int exp_reads,
                           output mmu_resp_t got);
    logic [31:0] va;
    mmu_resp_t   exp;
    int          start;
    int          cycles;
    va     = {page[31:12], 12'($urandom())};
    start  = mem_reads;
    cycles = 0;
    got    = '0;
    @(posedge clk);
    req_valid_i  <= 1'b1;
    req_i.vaddr  <= va;
    req_i.access <= acc;
    do begin
      @(posedge clk);
      cycles++;
    end while (!resp_valid_o && cycles < 100);
    req_valid_i <= 1'b0;
    if (!resp_valid_o) begin
      errors++;
      $display("No response arrived within 100 cycles for vaddr %h", va);
    end else begin
      got = resp_o;
      exp = ref_translate(va, acc);
      check("fault", 32'(got.fault), 32'(exp.fault));
      if (!exp.fault)
        check("paddr", got.paddr, exp.paddr);
      check("memory reads", 32'(mem_reads - start), 32'(exp_reads));
      check("read pending after response", 32'(walk_mem_valid_o), 32'd0);
    end
  endtask

  task automatic bare_mode_identity();
    mmu_resp_t r;
    int        e;
    e = errors;
    satp_i <= '0;
    translate(32'h8765_4000, ACC_LOAD, 0, r);
    translate(32'h8765_4000, ACC_STORE, 0, r);
    translate(32'h0000_1000, ACC_FETCH, 0, r);
    $display("bare mode: %0d errors", errors - e);
  endtask

  task automatic two_level_walk();
    mmu_resp_t r;
    int        e;
    e = errors;
    satp_i <= {1'b1, 9'h0, 22'(ROOT >> 12)};
    translate(VA_PAGE, ACC_LOAD, 2, r);
    check("first read address", read_addrs[$-1], ROOT + 32'(VA_PAGE[31:22]) * 4);
    check("second read address", read_addrs[$], L0 + 32'(VA_PAGE[21:12]) * 4);
    $display("two-level walk: %0d errors", errors - e);
  endtask

  task automatic tlb_reuse_and_split();
    mmu_resp_t r;
    int        e;
    e = errors;
    translate(VA_PAGE, ACC_STORE, 0, r);
    // Fetch misses in the ITLB even though the DTLB holds the page
    translate(VA_PAGE, ACC_FETCH, 2, r);
    translate(VA_PAGE, ACC_FETCH, 0, r);
    $display("TLB reuse: %0d errors", errors - e);
  endtask

  task automatic superpage_leaf();
    mmu_resp_t r;
    int        e;
    e = errors;
    translate(VA_SUPER, ACC_LOAD, 1, r);
    check("superpage VPN0", 32'(r.paddr[21:12]), 32'(VA_SUPER[21:12]));
    $display("superpage: %0d errors", errors - e);
  endtask

  task automatic permission_faults();
    mmu_resp_t r;
    int        e;
    // Invalid leaf, store to read-only, fetch without X, A clear, level-0 pointer
    access_t   accs [5] = '{ACC_LOAD, ACC_STORE, ACC_FETCH, ACC_LOAD, ACC_LOAD};
    e = errors;
    for (int i = 0; i < 5; i++) begin
      translate(32'h4041_8000 + (32'(i) << 12), accs[i], 2, r);
      check("fault expected", 32'(r.fault), 32'd1);
    end
    $display("faults: %0d errors", errors - e);
  endtask

  task automatic flush_forces_walk();
    mmu_resp_t r;
    int        e;
    e = errors;
    translate(VA_PAGE, ACC_LOAD, 0, r);
    @(posedge clk);
    tlb_flush_i <= 1'b1;
    @(posedge clk);
    tlb_flush_i <= 1'b0;
    translate(VA_PAGE, ACC_LOAD, 2, r);
    $display("flush: %0d errors", errors - e);
  endtask

  initial begin
    void'($urandom(32'h4880630a));
    resetn      = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    satp_i      = '0;
    tlb_flush_i = 1'b0;
    // Level-1 table with a pointer and a superpage leaf
    mem[ROOT + 32'h101 * 4] = make_pte(L0, 8'h01);
    mem[ROOT + 32'h0C0 * 4] = make_pte(32'h5540_0000, 8'hCF);
    // Level-0 table where entry 0x018 stays invalid
    mem[L0 + 32'h003 * 4] = make_pte(32'h1234_5000, 8'hCF);
    mem[L0 + 32'h019 * 4] = make_pte(32'h0009_1000, 8'hC3);
    mem[L0 + 32'h01A * 4] = make_pte(32'h0009_2000, 8'hC7);
    mem[L0 + 32'h01B * 4] = make_pte(32'h0009_3000, 8'h8F);
    mem[L0 + 32'h01C * 4] = make_pte(32'h0003_0000, 8'h01);
    repeat (2) @(posedge clk);
    resetn <= 1'b1;
    bare_mode_identity();
    two_level_walk();
    tlb_reuse_and_split();
    superpage_leaf();
    permission_faults();
    flush_forces_walk();
    $display("Tests run: %0d, errors: %0d", NUM_TESTS, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #(NUM_TESTS * 2000);
    $display("Watchdog expired before the tests finished");
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
rtl/sv32_pkg.sv
rtl/tlb_tag_ram.sv
rtl/sv32_table_walk.sv
rtl/mmu_access_check.sv
rtl/sv32_mmu.sv
testbench/tb_sv32_mmu.sv

// File: Makefile
# Verilator lint and simulation of the Sv32 MMU

TOP := tb_sv32_mmu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module sv32_mmu

sim:
	verilator --binary --timing -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "Result: PASSED" sim.log || (echo "Simulation failed" && exit 1)

clean:
	rm -rf obj_dir sim.log
